//--- verilog/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_M  = 2'd1,
        FWD_W  = 2'd2
    } fwd_sel_e;

    // funct3 encodings of the supported branches
    typedef enum logic [2:0] {
        BR_BEQ = 3'b000,
        BR_BNE = 3'b001,
        BR_BLT = 3'b100,
        BR_BGE = 3'b101
    } branch_e;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        alu_op_e     alu_op;
        logic        alu_src_b_imm;
        logic        alu_src_a_pc;
        logic        branch;
        logic        jump;
        logic        jalr;
        branch_e     branch_type;
        logic        halt;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc4;
    } fd_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
    } de_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        result_src_e     result_src;
        logic            mem_write;
        logic            halt;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] write_data;
        logic [XLEN-1:0] pc4;
        logic [4:0]      rd;
    } em_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        result_src_e     result_src;
        logic            halt;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] mem_data;
        logic [XLEN-1:0] pc4;
        logic [4:0]      rd;
    } mw_t;

endpackage

//--- verilog/fetch.sv
`timescale 1ns/100ps

module fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    trigger,
    input  logic                    pc_en,
    input  logic                    pc_src,
    input  logic [rv_pkg::XLEN-1:0] pc_target,
    input  logic                    imem_we,
    input  logic [7:0]              imem_addr,
    input  logic [31:0]             imem_wdata,
    output logic [rv_pkg::XLEN-1:0] instr,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic [rv_pkg::XLEN-1:0] pc4
);
    import rv_pkg::*;

    logic [XLEN-1:0] imem [IMEM_WORDS];

    assign pc4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (trigger && pc_en) begin
            pc <= pc_src ? pc_target : pc4;
        end
    end

    // program load only while the core is parked
    always_ff @(posedge clk) begin
        if (imem_we && !trigger) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign instr = imem[pc[$clog2(IMEM_WORDS)+1:2]];

endmodule

//--- verilog/decode.sv
`timescale 1ns/100ps

module decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] instr,
    input  logic                    wb_we,
    input  logic [4:0]              wb_rd,
    input  logic [rv_pkg::XLEN-1:0] wb_data,
    output rv_pkg::ctrl_t           ctrl,
    output logic [rv_pkg::XLEN-1:0] imm,
    output logic [rv_pkg::XLEN-1:0] rs1_val,
    output logic [rv_pkg::XLEN-1:0] rs2_val,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic                    uses_rs1,
    output logic                    uses_rs2,
    output logic [rv_pkg::XLEN-1:0] a0
);
    import rv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] regs [32];

    function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct3(funct3, instr[30]);
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write     = 1'b1;
                ctrl.alu_op        = alu_from_funct3(funct3, 1'b0);
                ctrl.alu_src_b_imm = 1'b1;
                imm                = imm_i;
                uses_rs1           = 1'b1;
            end
            OPC_LUI: begin
                ctrl.reg_write     = 1'b1;
                ctrl.alu_op        = ALU_PASS_B;
                ctrl.alu_src_b_imm = 1'b1;
                imm                = imm_u;
            end
            OPC_LOAD: begin
                ctrl.reg_write     = 1'b1;
                ctrl.result_src    = RES_MEM;
                ctrl.alu_src_b_imm = 1'b1;
                imm                = imm_i;
                uses_rs1           = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_write     = 1'b1;
                ctrl.alu_src_b_imm = 1'b1;
                imm                = imm_s;
                uses_rs1           = 1'b1;
                uses_rs2           = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch       = 1'b1;
                ctrl.branch_type  = branch_e'(funct3);
                ctrl.alu_src_a_pc = 1'b1;
                imm               = imm_b;
                uses_rs1          = 1'b1;
                uses_rs2          = 1'b1;
            end
            OPC_JAL: begin
                ctrl.reg_write    = 1'b1;
                ctrl.result_src   = RES_PC4;
                ctrl.jump         = 1'b1;
                ctrl.alu_src_a_pc = 1'b1;
                imm               = imm_j;
            end
            OPC_JALR: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = RES_PC4;
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                imm             = imm_i;
                uses_rs1        = 1'b1;
            end
            // only EBREAK from the system space
            OPC_SYSTEM: ctrl.halt = (funct3 == 3'b000) && (instr[31:20] == 12'h001);
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-first bypass from writeback
    assign rs1_val = (wb_we && wb_rd != 5'd0 && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (wb_we && wb_rd != 5'd0 && wb_rd == rs2) ? wb_data : regs[rs2];

    assign a0 = regs[10];

endmodule

//--- verilog/execute.sv
`timescale 1ns/100ps

module execute (
    input  rv_pkg::ctrl_t           ctrl,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] op_a,
    input  logic [rv_pkg::XLEN-1:0] op_b,
    input  logic [rv_pkg::XLEN-1:0] imm,
    output logic [rv_pkg::XLEN-1:0] alu_result,
    output logic                    branch_taken,
    output logic [rv_pkg::XLEN-1:0] target
);
    import rv_pkg::*;

    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] target_sum;
    logic            cond;

    assign alu_b = ctrl.alu_src_b_imm ? imm : op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - alu_b;
            ALU_AND:    alu_result = op_a & alu_b;
            ALU_OR:     alu_result = op_a | alu_b;
            ALU_XOR:    alu_result = op_a ^ alu_b;
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = op_a + alu_b;
        endcase
    end

    always_comb begin
        case (ctrl.branch_type)
            BR_BEQ:  cond = (op_a == op_b);
            BR_BNE:  cond = (op_a != op_b);
            BR_BLT:  cond = $signed(op_a) < $signed(op_b);
            BR_BGE:  cond = $signed(op_a) >= $signed(op_b);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.jump || (ctrl.branch && cond);

    // pc-relative for branches and jal, rs1-based for jalr
    assign target_sum = (ctrl.alu_src_a_pc ? pc : op_a) + imm;
    assign target     = ctrl.jalr ? {target_sum[XLEN-1:1], 1'b0} : target_sum;

endmodule

//--- verilog/memory.sv
`timescale 1ns/100ps

module memory (
    input  logic                    clk,
    input  logic                    we,
    input  logic [rv_pkg::XLEN-1:0] addr,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    output logic [rv_pkg::XLEN-1:0] rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] ram [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            ram[addr[$clog2(DMEM_WORDS)+1:2]] <= wdata;
        end
    end

    assign rdata = ram[addr[$clog2(DMEM_WORDS)+1:2]];

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [4:0]       d_rs1,
    input  logic [4:0]       d_rs2,
    input  logic             d_uses_rs1,
    input  logic             d_uses_rs2,
    input  logic             d_halt,
    input  rv_pkg::de_t      e_entry,
    input  rv_pkg::em_t      m_entry,
    input  rv_pkg::mw_t      w_entry,
    input  logic             branch_taken,
    output logic             pc_en,
    output logic             fd_en,
    output logic             de_bubble,
    output logic             flush,
    output logic             pc_src,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b,
    output logic             halted
);
    import rv_pkg::*;

    logic load_use;
    logic halt_seen;

    // newest producer wins
    function automatic fwd_sel_e fwd_pick(logic [4:0] src, em_t m, mw_t w);
        if (src == 5'd0) begin
            return FWD_RF;
        end else if (m.valid && m.reg_write && m.rd == src) begin
            return FWD_M;
        end else if (w.valid && w.reg_write && w.rd == src) begin
            return FWD_W;
        end
        return FWD_RF;
    endfunction

    assign fwd_a = fwd_pick(e_entry.rs1, m_entry, w_entry);
    assign fwd_b = fwd_pick(e_entry.rs2, m_entry, w_entry);

    assign load_use = e_entry.valid && e_entry.ctrl.result_src == RES_MEM
                      && e_entry.rd != 5'd0
                      && ((d_uses_rs1 && d_rs1 == e_entry.rd)
                          || (d_uses_rs2 && d_rs2 == e_entry.rd));

    assign flush     = e_entry.valid && branch_taken;
    assign pc_src    = flush;
    assign fd_en     = !load_use;
    assign de_bubble = load_use;

    // a redirect beats the halt, since that ebreak is on the wrong path
    assign pc_en = flush || !(load_use || halt_seen || d_halt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_seen <= 1'b0;
            halted    <= 1'b0;
        end else begin
            if (d_halt && !flush) begin
                halt_seen <= 1'b1;
            end
            if (w_entry.valid && w_entry.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/top.sv
`timescale 1ns/100ps

module top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    trigger,
    input  logic                    imem_we,
    input  logic [7:0]              imem_addr,
    input  logic [31:0]             imem_wdata,
    output logic [rv_pkg::XLEN-1:0] a0,
    output logic                    halted
);
    import rv_pkg::*;

    fd_t fd_q;
    de_t de_q;
    em_t em_q;
    mw_t mw_q;

    logic [XLEN-1:0] f_instr;
    logic [XLEN-1:0] f_pc;
    logic [XLEN-1:0] f_pc4;
    logic            fetch_valid;

    ctrl_t           d_ctrl;
    logic [XLEN-1:0] d_imm;
    logic [XLEN-1:0] d_rs1_val;
    logic [XLEN-1:0] d_rs2_val;
    logic [4:0]      d_rs1;
    logic [4:0]      d_rs2;
    logic [4:0]      d_rd;
    logic            d_uses_rs1;
    logic            d_uses_rs2;

    logic [XLEN-1:0] e_op_a;
    logic [XLEN-1:0] e_op_b;
    logic [XLEN-1:0] e_alu_result;
    logic [XLEN-1:0] e_target;
    logic            e_branch_taken;

    logic [XLEN-1:0] m_rdata;
    logic [XLEN-1:0] m_result;
    logic [XLEN-1:0] w_result;

    logic     pc_en;
    logic     fd_en;
    logic     de_bubble;
    logic     flush;
    logic     pc_src;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    function automatic logic [XLEN-1:0] pick_result(result_src_e src, logic [XLEN-1:0] alu,
                                                    logic [XLEN-1:0] mem, logic [XLEN-1:0] pc4);
        case (src)
            RES_MEM: return mem;
            RES_PC4: return pc4;
            default: return alu;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] pick_fwd(fwd_sel_e sel, logic [XLEN-1:0] rf,
                                                 logic [XLEN-1:0] m, logic [XLEN-1:0] w);
        case (sel)
            FWD_M:   return m;
            FWD_W:   return w;
            default: return rf;
        endcase
    endfunction

    fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .trigger    (trigger),
        .pc_en      (pc_en),
        .pc_src     (pc_src),
        .pc_target  (e_target),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .instr      (f_instr),
        .pc         (f_pc),
        .pc4        (f_pc4)
    );

    assign fetch_valid = trigger && pc_en;

    // empty slots carry a zero word, which decodes to no control
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            fd_q <= '0;
        end else if (fd_en) begin
            fd_q <= fetch_valid ? fd_t'{1'b1, f_instr, f_pc, f_pc4} : '0;
        end
    end

    decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (fd_q.instr),
        .wb_we    (mw_q.valid && mw_q.reg_write),
        .wb_rd    (mw_q.rd),
        .wb_data  (w_result),
        .ctrl     (d_ctrl),
        .imm      (d_imm),
        .rs1_val  (d_rs1_val),
        .rs2_val  (d_rs2_val),
        .rs1      (d_rs1),
        .rs2      (d_rs2),
        .rd       (d_rd),
        .uses_rs1 (d_uses_rs1),
        .uses_rs2 (d_uses_rs2),
        .a0       (a0)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || flush || de_bubble) begin
            de_q <= '0;
        end else begin
            de_q <= '{valid: fd_q.valid, ctrl: d_ctrl, pc: fd_q.pc, pc4: fd_q.pc4,
                      imm: d_imm, rs1_val: d_rs1_val, rs2_val: d_rs2_val,
                      rs1: d_rs1, rs2: d_rs2, rd: d_rd};
        end
    end

    assign e_op_a = pick_fwd(fwd_a, de_q.rs1_val, m_result, w_result);
    assign e_op_b = pick_fwd(fwd_b, de_q.rs2_val, m_result, w_result);

    execute u_execute (
        .ctrl         (de_q.ctrl),
        .pc           (de_q.pc),
        .op_a         (e_op_a),
        .op_b         (e_op_b),
        .imm          (de_q.imm),
        .alu_result   (e_alu_result),
        .branch_taken (e_branch_taken),
        .target       (e_target)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            em_q <= '0;
        end else begin
            em_q <= '{valid: de_q.valid, reg_write: de_q.ctrl.reg_write,
                      result_src: de_q.ctrl.result_src, mem_write: de_q.ctrl.mem_write,
                      halt: de_q.ctrl.halt, alu_result: e_alu_result,
                      write_data: e_op_b, pc4: de_q.pc4, rd: de_q.rd};
        end
    end

    memory u_memory (
        .clk   (clk),
        .we    (em_q.valid && em_q.mem_write),
        .addr  (em_q.alu_result),
        .wdata (em_q.write_data),
        .rdata (m_rdata)
    );

    assign m_result = pick_result(em_q.result_src, em_q.alu_result, m_rdata, em_q.pc4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mw_q <= '0;
        end else begin
            mw_q <= '{valid: em_q.valid, reg_write: em_q.reg_write,
                      result_src: em_q.result_src, halt: em_q.halt,
                      alu_result: em_q.alu_result, mem_data: m_rdata,
                      pc4: em_q.pc4, rd: em_q.rd};
        end
    end

    assign w_result = pick_result(mw_q.result_src, mw_q.alu_result, mw_q.mem_data, mw_q.pc4);

    hazard_unit u_hazard (
        .clk          (clk),
        .rst_n        (rst_n),
        .d_rs1        (d_rs1),
        .d_rs2        (d_rs2),
        .d_uses_rs1   (d_uses_rs1),
        .d_uses_rs2   (d_uses_rs2),
        .d_halt       (fd_q.valid && d_ctrl.halt),
        .e_entry      (de_q),
        .m_entry      (em_q),
        .w_entry      (mw_q),
        .branch_taken (e_branch_taken),
        .pc_en        (pc_en),
        .fd_en        (fd_en),
        .de_bubble    (de_bubble),
        .flush        (flush),
        .pc_src       (pc_src),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .halted       (halted)
    );

endmodule

//--- verification/tb_tests.svh
task automatic reset_defaults();
    apply_reset();
    repeat (3) @(negedge clk);
    check("a0", a0, 32'h0);
    check("halted", 32'(halted), 32'h0);
    prog.delete();
    prog.push_back(EBREAK);
    load_program();
    run_program();
    check("a0", a0, 32'h0);
    check("halted", 32'(halted), 32'h1);
    // halted only clears on reset
    apply_reset();
    @(negedge clk);
    check("halted", 32'(halted), 32'h0);
endtask

task automatic alu_forwarding();
    logic [31:0] a;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] t2;
    prog.delete();
    prog.push_back(i_type(12'h123, X0, F3_ADD, A0, OPC_I));
    a = 32'h123;
    prog.push_back(r_type(F7_BASE, A0, A0, F3_ADD, A0));
    a = a + a;
    prog.push_back(i_type(12'hff9, X0, F3_ADD, T0, OPC_I));
    t0 = sext12(12'hff9);
    prog.push_back(r_type(F7_SUB, T0, A0, F3_ADD, A0));
    a = a - t0;
    prog.push_back(r_type(F7_BASE, T0, A0, F3_XOR, A0));
    a = a ^ t0;
    prog.push_back(r_type(F7_BASE, T0, A0, F3_SLT, T2));
    t2 = ($signed(a) < $signed(t0)) ? 32'd1 : 32'd0;
    prog.push_back(u_type(20'h12345, T1));
    t1 = 32'h12345000;
    // a0 comes through the write-first register file here
    prog.push_back(r_type(F7_BASE, T1, A0, F3_AND, A0));
    a = a & t1;
    prog.push_back(r_type(F7_BASE, T2, A0, F3_OR, A0));
    a = a | t2;
    prog.push_back(r_type(F7_BASE, A0, A0, F3_ADD, A0));
    a = a + a;
    prog.push_back(EBREAK);
    load_program();
    run_program();
    check("a0", a0, a);
endtask

task automatic load_use_stall();
    logic [31:0] t0;
    logic [31:0] a;
    prog.delete();
    t0 = 32'h3a5;
    prog.push_back(i_type(12'h3a5, X0, F3_ADD, T0, OPC_I));
    prog.push_back(s_type(12'd16, T0, X0));
    prog.push_back(i_type(12'd16, X0, F3_LW, T1, OPC_LD));
    prog.push_back(i_type(12'h011, T1, F3_ADD, A0, OPC_I));
    a = t0 + 32'h11;
    prog.push_back(s_type(12'd20, A0, X0));
    prog.push_back(i_type(12'd20, X0, F3_LW, T2, OPC_LD));
    prog.push_back(r_type(F7_BASE, T2, A0, F3_ADD, A0));
    a = a + a;
    // loaded value goes straight into store data
    prog.push_back(i_type(12'd16, X0, F3_LW, S0, OPC_LD));
    prog.push_back(s_type(12'd24, S0, X0));
    prog.push_back(i_type(12'd24, X0, F3_LW, S1, OPC_LD));
    prog.push_back(r_type(F7_BASE, S1, A0, F3_ADD, A0));
    a = a + t0;
    prog.push_back(EBREAK);
    load_program();
    run_program();
    check("a0", a0, a);
endtask

task automatic branch_flush();
    logic [31:0] a;
    prog.delete();
    prog.push_back(i_type(12'h000, X0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'h005, X0, F3_ADD, T0, OPC_I));
    prog.push_back(i_type(12'h001, A0, F3_ADD, A0, OPC_I));
    prog.push_back(b_type(-4, A0, T0, F3_BNE));
    prog.push_back(b_type(12, A0, T0, F3_BEQ));
    prog.push_back(i_type(12'h100, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'h100, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'hfff, X0, F3_ADD, T1, OPC_I));
    // signed compare, -1 < 0
    prog.push_back(b_type(12, T1, X0, F3_BLT));
    prog.push_back(i_type(12'h200, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'h200, A0, F3_ADD, A0, OPC_I));
    prog.push_back(b_type(12, A0, T1, F3_BGE));
    prog.push_back(i_type(12'h400, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'h400, A0, F3_ADD, A0, OPC_I));
    // not taken from here on
    prog.push_back(b_type(8, A0, X0, F3_BEQ));
    prog.push_back(i_type(12'h010, A0, F3_ADD, A0, OPC_I));
    prog.push_back(b_type(8, A0, T1, F3_BLT));
    prog.push_back(i_type(12'h020, A0, F3_ADD, A0, OPC_I));
    prog.push_back(b_type(8, T1, A0, F3_BGE));
    prog.push_back(i_type(12'h040, A0, F3_ADD, A0, OPC_I));
    prog.push_back(EBREAK);
    // loop count, then only the fall-through adds; markers are flushed
    a = 32'd5 + 32'h10 + 32'h20 + 32'h40;
    load_program();
    run_program();
    check("a0", a0, a);
endtask

task automatic jump_links();
    logic [31:0] jal_link;
    logic [31:0] jalr_link;
    logic [31:0] hop_link;
    prog.delete();
    prog.push_back(j_type(8, A0));
    prog.push_back(i_type(12'h100, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'd28, X0, F3_ADD, T0, OPC_I));
    // odd offset, bit 0 of the target is dropped
    prog.push_back(i_type(12'd1, T0, 3'b000, T1, OPC_JALR));
    prog.push_back(i_type(12'h200, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'h200, A0, F3_ADD, A0, OPC_I));
    prog.push_back(i_type(12'h200, A0, F3_ADD, A0, OPC_I));
    // its link shows whether bit 0 was cleared
    prog.push_back(j_type(8, T2));
    prog.push_back(i_type(12'h400, A0, F3_ADD, A0, OPC_I));
    prog.push_back(r_type(F7_BASE, T1, A0, F3_ADD, A0));
    prog.push_back(r_type(F7_BASE, T2, A0, F3_ADD, A0));
    prog.push_back(EBREAK);
    jal_link  = 32'd0 * 4 + 4;
    jalr_link = 32'd3 * 4 + 4;
    hop_link  = 32'd7 * 4 + 4;
    load_program();
    run_program();
    check("a0", a0, jal_link + jalr_link + hop_link);
endtask

task automatic random_immediates();
    logic [31:0] a;
    logic [31:0] rnd;
    logic [11:0] imm;
    prog.delete();
    a = 32'h0;
    for (int k = 0; k < 10; k++) begin
        rnd = $random(seed);
        imm = rnd[11:0];
        if (k % 2 == 0) begin
            prog.push_back(i_type(imm, A0, F3_ADD, A0, OPC_I));
            a = a + sext12(imm);
        end else begin
            prog.push_back(i_type(imm, A0, F3_XOR, A0, OPC_I));
            a = a ^ sext12(imm);
        end
    end
    prog.push_back(EBREAK);
    load_program();
    run_program();
    check("a0", a0, a);
    // same program again from reset
    run_program();
    check("a0", a0, a);
endtask

//--- verification/tb_top.sv
`timescale 1ns/100ps

module tb_top;

    // seven runs of at most 200 cycles, their program loads, plus margin
    localparam int MAX_CYCLES = 2000;
    localparam int RUN_LIMIT  = 200;

    localparam logic [6:0] OPC_R    = 7'b0110011;
    localparam logic [6:0] OPC_I    = 7'b0010011;
    localparam logic [6:0] OPC_LUI  = 7'b0110111;
    localparam logic [6:0] OPC_LD   = 7'b0000011;
    localparam logic [6:0] OPC_ST   = 7'b0100011;
    localparam logic [6:0] OPC_BR   = 7'b1100011;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam logic [31:0] EBREAK = 32'h00100073;

    localparam logic [4:0] X0 = 5'd0;
    localparam logic [4:0] T0 = 5'd5;
    localparam logic [4:0] T1 = 5'd6;
    localparam logic [4:0] T2 = 5'd7;
    localparam logic [4:0] S0 = 5'd8;
    localparam logic [4:0] S1 = 5'd9;
    localparam logic [4:0] A0 = 5'd10;

    logic        clk;
    logic        rst_n;
    logic        trigger;
    logic        imem_we;
    logic [7:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic [31:0] a0;
    logic        halted;

    logic [31:0] prog [$];
    int          errors;
    int          checks;
    int          cycles;
    integer      seed;

    top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .trigger    (trigger),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .a0         (a0),
        .halted     (halted)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: simulation ran past %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_ST};
    endfunction

    // offset in bytes, relative to the branch
    function automatic logic [31:0] b_type(input int offset, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        logic [12:0] imm;
        imm = offset[12:0];
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BR};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] j_type(input int offset, input logic [4:0] rd);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n   = 1'b0;
        trigger = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // imem only accepts writes while the core is parked
    task automatic load_program();
        @(negedge clk);
        trigger = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = i[7:0];
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic run_program();
        int waited;
        waited = 0;
        apply_reset();
        trigger = 1'b1;
        while (!halted && waited < RUN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            errors++;
            $display("program did not halt within %0d cycles", RUN_LIMIT);
        end
        trigger = 1'b0;
    endtask

    `include "tb_tests.svh"

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        trigger    = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = 8'h00;
        imem_wdata = 32'h0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        seed       = 32'h221f;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        reset_defaults();
        alu_forwarding();
        load_use_stall();
        branch_flush();
        jump_links();
        random_immediates();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verification
verilog/rv_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/hazard_unit.sv
verilog/top.sv
verification/tb_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := tb_top
FILELIST  := vlog.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) verification/tb_tests.svh

.PHONY: all run check clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "sim passed" $(LOG)

check:
	@grep -qx "sim passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
